// ==== mul_pkg.sv ====
package mul_pkg;

	localparam int xlen   = 64;
	localparam int ext_w  = xlen + 2;    // two extra sign bits for the unsigned cases
	localparam int prod_w = 2 * ext_w;   // full width of a 66x66 product
	localparam int n_pp   = ext_w / 2;   // radix-4 gives one row per two bits

	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		MULW   = 3'd4
	} mul_op_e;

	// which part of the product goes back to the core
	typedef enum logic [1:0] {
		SEL_LO   = 2'd0,   // bits 63:0
		SEL_HI   = 2'd1,   // bits 127:64
		SEL_WORD = 2'd2    // bits 31:0, sign extended
	} res_sel_e;

	typedef logic [4:0] mul_tag_t;   // destination register

	typedef struct packed {
		mul_op_e         op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		mul_tag_t        tag;
	} mul_req_t;

	typedef struct packed {
		logic [ext_w-1:0] a_ext;   // multiplier, scanned by the booth groups
		logic [ext_w-1:0] b_ext;   // multiplicand
		res_sel_e         sel;
		mul_tag_t         tag;
	} mul_opnd_t;

	typedef struct packed {
		logic [xlen-1:0] result;
		mul_tag_t        tag;
	} mul_resp_t;

endpackage

// ==== mul_decode.sv ====
`timescale 1ns/1ps

module mul_decode import mul_pkg::*; (
	input  mul_req_t  req,
	output mul_opnd_t opnd
);

	logic            signed_a;
	logic            signed_b;
	logic [xlen-1:0] a_val;
	logic [xlen-1:0] b_val;

	// only MULHU treats a as unsigned, MULHSU and MULHU treat b as unsigned
	always_comb begin
		signed_a = (req.op != MULHU);
		signed_b = (req.op == MUL) || (req.op == MULH) || (req.op == MULW);
	end

	// word ops work on the low halves, sign extended
	always_comb begin
		a_val = req.a;
		b_val = req.b;
		if (req.op == MULW) begin
			a_val[xlen-1:xlen/2] = {(xlen/2){req.a[xlen/2-1]}};
			b_val[xlen-1:xlen/2] = {(xlen/2){req.b[xlen/2-1]}};
		end
	end

	always_comb begin
		opnd.a_ext = {{2{signed_a & a_val[xlen-1]}}, a_val};
		opnd.b_ext = {{2{signed_b & b_val[xlen-1]}}, b_val};
		case (req.op)
			MULH, MULHSU, MULHU: opnd.sel = SEL_HI;
			MULW:                opnd.sel = SEL_WORD;
			default:             opnd.sel = SEL_LO;   // MUL and unused codes
		endcase
		opnd.tag = req.tag;
	end

endmodule

// ==== booth_partial.sv ====
`timescale 1ns/1ps

module booth_partial import mul_pkg::*; (
	input  logic                           clk,
	input  logic                           in_valid,
	input  mul_opnd_t                      opnd,
	output logic [n_pp-1:0][prod_w-1:0]    pp,
	output logic [n_pp-1:0]                pp_neg,
	output res_sel_e                       sel,
	output mul_tag_t                       tag
);

	logic [ext_w:0]                 a_grp;     // a_ext with the implicit zero below bit 0
	logic [prod_w-1:0]              b_one;     // +b sign extended to product width
	logic [prod_w-1:0]              b_two;     // +2b
	logic [2:0]                     grp;
	logic [prod_w-1:0]              mult;
	logic [n_pp-1:0][prod_w-1:0]    pp_c;
	logic [n_pp-1:0]                neg_c;

	assign a_grp = {opnd.a_ext, 1'b0};
	assign b_one = {{(prod_w-ext_w){opnd.b_ext[ext_w-1]}}, opnd.b_ext};
	assign b_two = {b_one[prod_w-2:0], 1'b0};

	// group i looks at a[2i+1], a[2i], a[2i-1]
	always_comb begin
		grp   = '0;
		mult  = '0;
		for (int i = 0; i < n_pp; i++) begin
			grp = a_grp[2*i +: 3];
			case (grp)
				3'b001, 3'b010: mult = b_one;
				3'b011:         mult = b_two;
				3'b100:         mult = ~b_two;   // -2b, +1 added later
				3'b101, 3'b110: mult = ~b_one;   // -b
				default:        mult = '0;       // 000 and 111
			endcase
			neg_c[i] = grp[2] & ~(grp[1] & grp[0]);
			pp_c[i]  = mult << (2 * i);          // zeros fill below the row
		end
	end

	/*
	 * Inverting before the shift keeps the low bits of each row at zero,
	 * so the missing +1 of a negative row sits exactly at bit 2i and the
	 * tree can add it there.
	 */
	always_ff @(posedge clk) begin
		if (in_valid) begin
			pp     <= pp_c;
			pp_neg <= neg_c;
			sel    <= opnd.sel;
			tag    <= opnd.tag;
		end
	end

endmodule

// ==== wallace_tree.sv ====
`timescale 1ns/1ps

module wallace_tree import mul_pkg::*; (
	input  logic                           clk,
	input  logic                           in_valid,
	input  logic [n_pp-1:0][prod_w-1:0]    pp,
	input  logic [n_pp-1:0]                pp_neg,
	input  res_sel_e                       sel,
	input  mul_tag_t                       tag,
	output logic [prod_w-1:0]              sum_vec,
	output logic [prod_w-1:0]              carry_vec,   // weight 1, shifted by the adder
	output res_sel_e                       csa_sel,
	output mul_tag_t                       csa_tag
);

	// rows left after lvl levels of 3:2 compression
	function automatic int rows_at(input int lvl);
		int r;
		r = n_pp + 1;
		for (int k = 0; k < lvl; k++) begin
			r = (r / 3) * 2 + r % 3;
		end
		return r;
	endfunction

	function automatic int level_count();
		int r;
		int l;
		r = n_pp + 1;
		l = 0;
		while (r > 2) begin
			r = (r / 3) * 2 + r % 3;
			l++;
		end
		return l;
	endfunction

	localparam int n_lvl = level_count();   // 34 rows take 8 levels

	logic [prod_w-1:0] neg_row;
	logic [prod_w-1:0] sum_c;
	logic [prod_w-1:0] carry_c;

	// correction bits never overlap, so they share one extra row
	always_comb begin
		neg_row = '0;
		for (int i = 0; i < n_pp; i++) begin
			neg_row[2*i] = pp_neg[i];
		end
	end

	for (genvar lv = 0; lv <= n_lvl; lv++) begin : g_lvl
		localparam int n_row = rows_at(lv);
		logic [prod_w-1:0] row [n_row];

		if (lv == 0) begin : g_init
			for (genvar r = 0; r < n_pp; r++) begin : g_pp
				assign row[r] = pp[r];
			end
			assign row[n_pp] = neg_row;
		end else begin : g_csa
			localparam int n_prev = rows_at(lv - 1);
			localparam int n_grp  = n_prev / 3;

			for (genvar g = 0; g < n_grp; g++) begin : g_add
				logic [prod_w-1:0] x;
				logic [prod_w-1:0] y;
				logic [prod_w-1:0] z;
				logic [prod_w-1:0] maj;

				assign x   = g_lvl[lv-1].row[3*g];
				assign y   = g_lvl[lv-1].row[3*g+1];
				assign z   = g_lvl[lv-1].row[3*g+2];
				assign maj = (x & y) | (x & z) | (y & z);
				assign row[2*g] = x ^ y ^ z;
				// last level leaves the carry unshifted for the final adder
				assign row[2*g+1] = (lv == n_lvl) ? maj : {maj[prod_w-2:0], 1'b0};
			end

			for (genvar p = 0; p < n_prev % 3; p++) begin : g_pass
				assign row[2*n_grp+p] = g_lvl[lv-1].row[3*n_grp+p];   // left over rows
			end
		end
	end

	assign sum_c   = g_lvl[n_lvl].row[0];
	assign carry_c = g_lvl[n_lvl].row[1];

	always_ff @(posedge clk) begin
		if (in_valid) begin
			sum_vec   <= sum_c;
			carry_vec <= carry_c;
			csa_sel   <= sel;
			csa_tag   <= tag;
		end
	end

endmodule

// ==== mul_result.sv ====
`timescale 1ns/1ps

module mul_result import mul_pkg::*; (
	input  logic              clk,
	input  logic              in_valid,
	input  logic [prod_w-1:0] sum_vec,
	input  logic [prod_w-1:0] carry_vec,
	input  res_sel_e          sel,
	input  mul_tag_t          tag,
	output mul_resp_t         resp
);

	logic [prod_w-1:0] prod;
	logic [xlen-1:0]   res_c;

	// carry-propagate add, the carry vector has weight two
	assign prod = sum_vec + {carry_vec[prod_w-2:0], 1'b0};

	always_comb begin
		case (sel)
			SEL_HI:   res_c = prod[2*xlen-1:xlen];
			SEL_WORD: res_c = {{(xlen/2){prod[xlen/2-1]}}, prod[xlen/2-1:0]};
			default:  res_c = prod[xlen-1:0];
		endcase
	end

	/*
	 * Bits above 127 only carry the sign of the 66-bit product and are
	 * never returned. The 132-bit wrap of the sum is harmless for the
	 * same reason.
	 */
	always_ff @(posedge clk) begin
		if (in_valid) begin
			resp.result <= res_c;
			resp.tag    <= tag;
		end
	end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      req_valid,
	input  mul_req_t  req,
	input  logic      flush,
	output logic      resp_valid,
	output mul_resp_t resp
);

	logic [2:0]                     valid_q;   // bit i set when stage i+1 holds a live request
	mul_opnd_t                      opnd;
	logic [n_pp-1:0][prod_w-1:0]    pp;
	logic [n_pp-1:0]                pp_neg;
	res_sel_e                       pp_sel;
	mul_tag_t                       pp_tag;
	logic [prod_w-1:0]              sum_vec;
	logic [prod_w-1:0]              carry_vec;
	res_sel_e                       csa_sel;
	mul_tag_t                       csa_tag;

	// flush also kills a request arriving in the same cycle
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[1:0], req_valid};
		end
	end

	assign resp_valid = valid_q[2];

	mul_decode u_decode (
		.req  (req),
		.opnd (opnd)
	);

	booth_partial u_booth (
		.clk      (clk),
		.in_valid (req_valid),   // captures on the accepting edge
		.opnd     (opnd),
		.pp       (pp),
		.pp_neg   (pp_neg),
		.sel      (pp_sel),
		.tag      (pp_tag)
	);

	wallace_tree u_tree (
		.clk       (clk),
		.in_valid  (valid_q[0]),
		.pp        (pp),
		.pp_neg    (pp_neg),
		.sel       (pp_sel),
		.tag       (pp_tag),
		.sum_vec   (sum_vec),
		.carry_vec (carry_vec),
		.csa_sel   (csa_sel),
		.csa_tag   (csa_tag)
	);

	mul_result u_result (
		.clk       (clk),
		.in_valid  (valid_q[1]),
		.sum_vec   (sum_vec),
		.carry_vec (carry_vec),
		.sel       (csa_sel),
		.tag       (csa_tag),
		.resp      (resp)
	);

endmodule

// ==== tb_mul_model.svh ====
`ifndef TB_MUL_MODEL_SVH
`define TB_MUL_MODEL_SVH

// one expected response in request order
typedef struct packed {
	mul_op_e         op;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	mul_tag_t        tag;
	logic [xlen-1:0] result;
	logic [31:0]     issue;    // cycle count when the request was driven
} exp_entry_t;

logic [63:0] rng_state = 64'd52;

// xorshift64 step whose state never reaches zero from a nonzero seed
function automatic logic [63:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 7);
	rng_state = rng_state ^ (rng_state << 17);
	return rng_state;
endfunction

// full 128-bit product from the ISA rules and the field the op asks for
function automatic logic [xlen-1:0] model_result(input mul_op_e op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
	logic            a_signed;
	logic            b_signed;
	logic [127:0]    a_wide;
	logic [127:0]    b_wide;
	logic [127:0]    full;
	logic [31:0]     word;
	logic [xlen-1:0] res;
	a_signed = (op == MUL) || (op == MULH) || (op == MULHSU);
	b_signed = (op == MUL) || (op == MULH);
	a_wide   = a_signed ? {{64{a[63]}}, a} : {64'd0, a};
	b_wide   = b_signed ? {{64{b[63]}}, b} : {64'd0, b};
	full     = a_wide * b_wide;
	word     = a[31:0] * b[31:0];    // low word does not depend on the upper halves
	case (op)
		MUL:     res = full[63:0];
		MULW:    res = {{32{word[31]}}, word};
		default: res = full[127:64];
	endcase
	return res;
endfunction

task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
		input string what);
	check_count++;
	if (got !== expected) begin
		$display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, expected);
		error_count++;
	end
endtask

`endif

// ==== tb_mul_unit.sv ====
`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

	localparam int n_idle  = 20;
	localparam int n_low   = 1000;    // 500 MUL then 500 MULW
	localparam int n_high  = 1500;    // 500 each of MULH, MULHSU, MULHU
	localparam int n_gap   = 600;     // cycles of gapped strobes
	localparam int n_flush = 400;     // cycles of the flush stream
	localparam int n_tests = 5;
	localparam int timeout_limit = n_idle + n_low + n_high + n_gap + n_flush + 5 * n_tests + 100;

	logic      clk;
	logic      reset;
	logic      req_valid;
	mul_req_t  req;
	logic      flush;
	logic      resp_valid;
	mul_resp_t resp;

	int cyc         = 0;
	int error_count = 0;
	int check_count = 0;
	int tests_done  = 0;
	int issued;
	int dropped;
	int resp_count;
	int test_errors;

	`include "tb_mul_model.svh"

	exp_entry_t exp_q[$];

	mul_unit uut (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.flush      (flush),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= timeout_limit) begin
			$display("timeout: no end of run after %0d cycles", timeout_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// random values with the usual corners mixed in
	function automatic logic [xlen-1:0] rand_operand();
		logic [63:0]     pick;
		logic [xlen-1:0] val;
		pick = next_rand();
		case (pick[2:0])
			3'd4:    val = '0;
			3'd5:    val = '1;
			3'd6:    val = {1'b1, {(xlen-1){1'b0}}};
			3'd7:    val = 64'd1;
			default: val = next_rand();
		endcase
		return val;
	endfunction

	function automatic mul_req_t make_req(input mul_op_e op);
		mul_req_t    r;
		logic [63:0] rv;
		rv    = next_rand();
		r.op  = op;
		r.a   = rand_operand();
		r.b   = rand_operand();
		r.tag = rv[4:0];
		return r;
	endfunction

	task automatic take_response();
		exp_entry_t e;
		mul_op_e    op_l;
		string      msg;
		if (resp_valid) begin
			resp_count++;
			if (exp_q.size() == 0) begin
				$display("error at %0t: response with tag %0d but no request outstanding",
					$time, resp.tag);
				error_count++;
			end else begin
				e    = exp_q.pop_front();
				op_l = e.op;
				msg  = $sformatf("op %s a %h b %h tag %0d", op_l.name(), e.a, e.b, e.tag);
				check_value(resp.result, e.result, {msg, " result"});
				check_value(64'(resp.tag), 64'(e.tag), {msg, " tag"});
				check_value(64'(cyc - int'(e.issue)), 64'd3, {msg, " latency"});
			end
		end
	endtask

	// one cycle that samples outputs at the falling edge and then drives the next inputs
	task automatic step(input logic valid, input mul_req_t r, input logic fl);
		exp_entry_t e;
		@(negedge clk);
		take_response();
		req_valid = valid;
		req       = r;
		flush     = fl;
		if (valid) begin
			e.op     = r.op;
			e.a      = r.a;
			e.b      = r.b;
			e.tag    = r.tag;
			e.result = model_result(r.op, r.a, r.b);
			e.issue  = 32'(cyc);
			exp_q.push_back(e);
			issued++;
		end
		// flush kills this request and the two still in the pipe
		if (fl) begin
			while (exp_q.size() > 0 && int'(exp_q[exp_q.size()-1].issue) >= cyc - 2) begin
				void'(exp_q.pop_back());
				dropped++;
			end
		end
	endtask

	task automatic begin_test();
		issued      = 0;
		dropped     = 0;
		resp_count  = 0;
		test_errors = error_count;
	endtask

	task automatic end_test(input string name);
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < 4) begin
			step(1'b0, '0, 1'b0);
			waited++;
		end
		step(1'b0, '0, 1'b0);    // catches a stray late response
		if (exp_q.size() > 0) begin
			$display("error in %s: %0d expected responses never arrived", name, exp_q.size());
			error_count++;
			exp_q.delete();
		end
		check_value(64'(resp_count), 64'(issued - dropped), {name, " response count"});
		tests_done++;
		$display("test %s done: %0d requests, %0d flushed, %0d responses, %0d errors",
			name, issued, dropped, resp_count, error_count - test_errors);
	endtask

	initial begin
		logic [63:0] rv;
		$timeformat(-9, 0, " ns", 0);
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		flush     = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		begin_test();
		repeat (n_idle) step(1'b0, '0, 1'b0);
		end_test("idle");

		begin_test();
		for (int i = 0; i < n_low; i++) begin
			step(1'b1, make_req((i < n_low / 2) ? MUL : MULW), 1'b0);
		end
		end_test("mul_low");

		begin_test();
		for (int i = 0; i < n_high; i++) begin
			step(1'b1, make_req((i < 500) ? MULH : (i < 1000) ? MULHSU : MULHU), 1'b0);
		end
		end_test("mul_high");

		begin_test();
		for (int i = 0; i < n_gap; i++) begin
			rv = next_rand();
			step(rv[0], make_req(mul_op_e'(rv[10:8] % 3'd5)), 1'b0);
		end
		end_test("gapped");

		begin_test();
		for (int i = 0; i < n_flush; i++) begin
			rv = next_rand();
			step(rv[1:0] != 2'b00, make_req(mul_op_e'(rv[10:8] % 3'd5)), rv[7:4] == 4'd0);
		end
		end_test("flush");

		$display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
mul_pkg.sv
mul_decode.sv
booth_partial.sv
wallace_tree.sv
mul_result.sv
mul_unit.sv
tb_mul_unit.sv

// ==== Makefile ====
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_mul_unit
FILE_LIST ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
